//--- common/tttPkg.sv
package tttPkg;

	localparam int numCells = 9;

	typedef logic [3:0] cellIdx_t;   // 0..8, row by row from top left
	typedef logic [8:0] board_t;     // bit i is cell i
	typedef logic [3:0] bcdDigit_t;
	typedef logic [7:0] segCode_t;   // active low, dot in bit 7
	typedef logic [3:0] anode_t;     // active low

	typedef enum logic {
		PLAYER_X,
		PLAYER_O
	} player_t;

	typedef enum logic [1:0] {
		PLAYING,
		X_WON,
		O_WON,
		DRAW
	} result_t;

	////////////////////////////////////////
	// winning masks
	////////////////////////////////////////
	localparam board_t winLines [8] = '{
		9'b000_000_111,   // rows
		9'b000_111_000,
		9'b111_000_000,
		9'b001_001_001,   // columns
		9'b010_010_010,
		9'b100_100_100,
		9'b100_010_001,   // diagonals
		9'b001_010_100
	};

	function automatic logic hasLine(input board_t b);
		logic found;
		found = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if ((b & winLines[i]) == winLines[i])
				found = 1'b1;
		end
		return found;
	endfunction

	////////////////////////////////////////
	// seven segment codes for 0..9
	////////////////////////////////////////
	localparam segCode_t segCodes [10] = '{
		8'b11000000,
		8'b11111001,
		8'b10100100,
		8'b10110000,
		8'b10011001,
		8'b10010010,
		8'b10000010,
		8'b11111000,
		8'b10000000,
		8'b10010000
	};

endpackage

//--- keypad/debouncer.sv
`timescale 1ns/1ps

module debouncer #(
	parameter int debounceCycles = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic raw_i,
	output logic level_o,
	output logic rise_o
);
	localparam int cntW = $clog2(debounceCycles + 1);

	logic [1:0] syncFf;
	logic [cntW-1:0] stableCnt;
	logic differs;
	logic settled;

	assign differs = syncFf[1] != level_o;
	assign settled = differs && (stableCnt == cntW'(debounceCycles - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			syncFf <= 2'b00;
		end else begin
			syncFf <= {syncFf[0], raw_i};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stableCnt <= '0;
			level_o <= 1'b0;
			rise_o <= 1'b0;
		end else begin
			rise_o <= settled && syncFf[1];   // low to high only
			if (!differs) begin
				stableCnt <= '0;   // bounce restarts the count
			end else if (settled) begin
				stableCnt <= '0;
				level_o <= syncFf[1];
			end else begin
				stableCnt <= stableCnt + 1'b1;
			end
		end
	end

	risePulse: assert property (@(posedge clk) disable iff (rst) rise_o |=> !rise_o);

endmodule

//--- keypad/keypadDecoder.sv
`timescale 1ns/1ps

module keypadDecoder #(
	parameter int debounceCycles = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic [2:0] keyRows_i,
	input  logic [2:0] keyCols_i,
	output logic moveValid_o,
	output tttPkg::cellIdx_t moveCell_o
);
	import tttPkg::*;

	logic [2:0] rowLevel;
	logic [2:0] colLevel;
	logic [2:0] rowRise;
	logic [2:0] colRise;
	logic oneRow;
	logic oneCol;
	logic anyKey;
	logic multiKey;
	logic keyHeld;
	logic fire;
	cellIdx_t cellNext;

	function automatic logic [1:0] hotIdx(input logic [2:0] hot);
		logic [1:0] idx;
		idx = 2'd0;
		if (hot[1])
			idx = 2'd1;
		if (hot[2])
			idx = 2'd2;
		return idx;
	endfunction

	for (genvar i = 0; i < 3; i++) begin : genDeb
		debouncer #(.debounceCycles(debounceCycles)) rowDeb (
			.clk(clk), .rst(rst), .raw_i(keyRows_i[i]), .level_o(rowLevel[i]), .rise_o(rowRise[i])
		);
		debouncer #(.debounceCycles(debounceCycles)) colDeb (
			.clk(clk), .rst(rst), .raw_i(keyCols_i[i]), .level_o(colLevel[i]), .rise_o(colRise[i])
		);
	end

	assign oneRow = $onehot(rowLevel);
	assign oneCol = $onehot(colLevel);
	assign anyKey = |{rowLevel, colLevel};
	assign multiKey = (|rowLevel && !oneRow) || (|colLevel && !oneCol);
	// a rise completes the pattern
	assign fire = oneRow && oneCol && |{rowRise, colRise} && !keyHeld;
	assign cellNext = cellIdx_t'(3 * hotIdx(rowLevel) + hotIdx(colLevel));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			moveValid_o <= 1'b0;
			keyHeld <= 1'b0;
		end else begin
			moveValid_o <= fire;
			if (!anyKey)
				keyHeld <= 1'b0;   // all released
			else if (fire || multiKey)
				keyHeld <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fire)
			moveCell_o <= cellNext;
	end

	cellInRange: assert property (@(posedge clk) disable iff (rst)
		moveValid_o |-> moveCell_o < numCells);

endmodule

//--- game/gameBoard.sv
`timescale 1ns/1ps

module gameBoard (
	input  logic clk,
	input  logic rst,
	input  logic newGame_i,
	input  logic moveValid_i,
	input  tttPkg::cellIdx_t moveCell_i,
	output tttPkg::board_t xBoard_o,
	output tttPkg::board_t oBoard_o,
	output tttPkg::result_t result_o,
	output logic resultValid_o,
	output logic invalidMove_o
);
	import tttPkg::*;

	player_t turn;
	board_t cellMask;
	board_t xNext;
	board_t oNext;
	logic occupied;
	logic moveOk;

	assign cellMask = board_t'(1) << moveCell_i;
	assign occupied = |((xBoard_o | oBoard_o) & cellMask);
	assign moveOk = (moveCell_i < numCells) && !occupied && (result_o == PLAYING);

	// boards as they would be after the move
	assign xNext = (turn == PLAYER_X) ? (xBoard_o | cellMask) : xBoard_o;
	assign oNext = (turn == PLAYER_O) ? (oBoard_o | cellMask) : oBoard_o;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			xBoard_o <= '0;
			oBoard_o <= '0;
			turn <= PLAYER_X;
			result_o <= PLAYING;
			resultValid_o <= 1'b0;
			invalidMove_o <= 1'b0;
		end else begin
			resultValid_o <= 1'b0;
			if (newGame_i) begin
				xBoard_o <= '0;
				oBoard_o <= '0;
				turn <= PLAYER_X;
				result_o <= PLAYING;
				invalidMove_o <= 1'b0;
			end else if (moveValid_i) begin
				if (!moveOk) begin
					invalidMove_o <= 1'b1;   // board and turn stay
				end else begin
					xBoard_o <= xNext;
					oBoard_o <= oNext;
					invalidMove_o <= 1'b0;
					turn <= (turn == PLAYER_X) ? PLAYER_O : PLAYER_X;
					if (turn == PLAYER_X && hasLine(xNext)) begin
						result_o <= X_WON;
						resultValid_o <= 1'b1;
					end else if (turn == PLAYER_O && hasLine(oNext)) begin
						result_o <= O_WON;
						resultValid_o <= 1'b1;
					end else if (&(xNext | oNext)) begin
						result_o <= DRAW;
						resultValid_o <= 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	noOverlap: assert property (@(posedge clk) disable iff (rst)
		(xBoard_o & oBoard_o) == '0);

endmodule

//--- game/scoreKeeper.sv
`timescale 1ns/1ps

module scoreKeeper (
	input  logic clk,
	input  logic rst,
	input  logic clearScore_i,
	input  logic resultValid_i,
	input  tttPkg::result_t result_i,
	output tttPkg::bcdDigit_t xTens_o,
	output tttPkg::bcdDigit_t xOnes_o,
	output tttPkg::bcdDigit_t oTens_o,
	output tttPkg::bcdDigit_t oOnes_o
);
	import tttPkg::*;

	// two digit decimal increment, 99 wraps to 00
	function automatic logic [7:0] bcdInc(input bcdDigit_t tens, input bcdDigit_t ones);
		bcdDigit_t nextTens;
		bcdDigit_t nextOnes;
		nextTens = tens;
		nextOnes = ones + 4'd1;
		if (ones == 4'd9) begin
			nextOnes = 4'd0;
			nextTens = (tens == 4'd9) ? 4'd0 : tens + 4'd1;
		end
		return {nextTens, nextOnes};
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			xTens_o <= '0;
			xOnes_o <= '0;
			oTens_o <= '0;
			oOnes_o <= '0;
		end else if (clearScore_i) begin
			xTens_o <= '0;
			xOnes_o <= '0;
			oTens_o <= '0;
			oOnes_o <= '0;
		end else if (resultValid_i) begin
			if (result_i == X_WON)
				{xTens_o, xOnes_o} <= bcdInc(xTens_o, xOnes_o);
			else if (result_i == O_WON)
				{oTens_o, oOnes_o} <= bcdInc(oTens_o, oOnes_o);
			// draw leaves the score alone
		end
	end

	digitsDecimal: assert property (@(posedge clk) disable iff (rst)
		xTens_o < 10 && xOnes_o < 10 && oTens_o < 10 && oOnes_o < 10);

endmodule

//--- display/segDisplay.sv
`timescale 1ns/1ps

module segDisplay #(
	parameter int refreshDiv = 50000
) (
	input  logic clk,
	input  logic rst,
	input  tttPkg::bcdDigit_t d0_i,
	input  tttPkg::bcdDigit_t d1_i,
	input  tttPkg::bcdDigit_t d2_i,
	input  tttPkg::bcdDigit_t d3_i,
	output tttPkg::segCode_t seg_o,
	output tttPkg::anode_t an_o
);
	import tttPkg::*;

	localparam int divW = $clog2(refreshDiv + 1);

	logic [divW-1:0] divCnt;
	logic tick;
	logic [1:0] digitSel;
	bcdDigit_t curDigit;

	assign tick = divCnt == divW'(refreshDiv - 1);

	// refresh enable
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			divCnt <= '0;
		else if (tick)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	always_comb begin
		case (digitSel)
			2'd0: curDigit = d0_i;
			2'd1: curDigit = d1_i;
			2'd2: curDigit = d2_i;
			default: curDigit = d3_i;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			digitSel <= 2'd0;
			an_o <= '1;   // blank until first tick
			seg_o <= '1;
		end else if (tick) begin
			an_o <= ~(anode_t'(1) << digitSel);
			seg_o <= (curDigit < 4'd10) ? segCodes[curDigit] : '1;
			digitSel <= digitSel + 2'd1;
		end
	end

endmodule

//--- design/tttTop.sv
`timescale 1ns/1ps

module tttTop #(
	parameter int debounceCycles = 100000,
	parameter int refreshDiv = 50000
) (
	input  logic clk,
	input  logic rst,
	input  logic [2:0] keyRows_i,
	input  logic [2:0] keyCols_i,
	input  logic newGameBtn_i,
	input  logic clearScoreBtn_i,
	output tttPkg::board_t xBoard_o,
	output tttPkg::board_t oBoard_o,
	output tttPkg::result_t result_o,
	output logic invalidMove_o,
	output tttPkg::segCode_t seg_o,
	output tttPkg::anode_t an_o
);
	import tttPkg::*;

	logic newGame;
	logic clearScore;
	logic moveValid;
	logic resultValid;
	cellIdx_t moveCell;
	bcdDigit_t xTens;
	bcdDigit_t xOnes;
	bcdDigit_t oTens;
	bcdDigit_t oOnes;

	// buttons only need the press strobe
	debouncer #(.debounceCycles(debounceCycles)) newGameDeb (
		.clk(clk), .rst(rst), .raw_i(newGameBtn_i), .level_o(), .rise_o(newGame)
	);

	debouncer #(.debounceCycles(debounceCycles)) clearScoreDeb (
		.clk(clk), .rst(rst), .raw_i(clearScoreBtn_i), .level_o(), .rise_o(clearScore)
	);

	keypadDecoder #(.debounceCycles(debounceCycles)) keypad (
		.clk(clk), .rst(rst), .keyRows_i(keyRows_i), .keyCols_i(keyCols_i),
		.moveValid_o(moveValid), .moveCell_o(moveCell)
	);

	gameBoard game (
		.clk(clk), .rst(rst), .newGame_i(newGame),
		.moveValid_i(moveValid), .moveCell_i(moveCell),
		.xBoard_o(xBoard_o), .oBoard_o(oBoard_o), .result_o(result_o),
		.resultValid_o(resultValid), .invalidMove_o(invalidMove_o)
	);

	scoreKeeper score (
		.clk(clk), .rst(rst), .clearScore_i(clearScore),
		.resultValid_i(resultValid), .result_i(result_o),
		.xTens_o(xTens), .xOnes_o(xOnes), .oTens_o(oTens), .oOnes_o(oOnes)
	);

	// X score on the left two digits
	segDisplay #(.refreshDiv(refreshDiv)) scoreboard (
		.clk(clk), .rst(rst),
		.d0_i(oOnes), .d1_i(oTens), .d2_i(xOnes), .d3_i(xTens),
		.seg_o(seg_o), .an_o(an_o)
	);

endmodule

//--- tests/tttTb.sv
`timescale 1ns/1ps

module tttTb;
	import tttPkg::*;

	localparam int debounceCycles = 4;
	localparam int refreshDiv = 3;
	localparam int holdCycles = debounceCycles + 8;
	localparam int cyclesPerCase = 40;

	logic clk;
	logic rst;
	logic [2:0] keyRows;
	logic [2:0] keyCols;
	logic newGameBtn;
	logic clearScoreBtn;
	board_t xBoard;
	board_t oBoard;
	result_t result;
	logic invalidMove;
	segCode_t seg;
	anode_t an;

	// cases as read from the file
	string nameQ[$];
	string opQ[$];
	int argQ[$];
	board_t xQ[$];
	board_t oQ[$];
	result_t resQ[$];
	logic invQ[$];
	bcdDigit_t digQ[$];   // xTens, xOnes, oTens, oOnes per case

	bcdDigit_t shownDigit [4];   // index is the anode position
	int cycleCount;
	int cycleLimit;

	tttTop #(.debounceCycles(debounceCycles), .refreshDiv(refreshDiv)) DUT (
		.clk(clk), .rst(rst), .keyRows_i(keyRows), .keyCols_i(keyCols),
		.newGameBtn_i(newGameBtn), .clearScoreBtn_i(clearScoreBtn),
		.xBoard_o(xBoard), .oBoard_o(oBoard), .result_o(result),
		.invalidMove_o(invalidMove), .seg_o(seg), .an_o(an)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// failure handling and compares
	////////////////////////////////////////
	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
			abortRun($sformatf("timeout: no finish within %0d cycles", cycleLimit));
	end

	task automatic boardCheck(input string name, input string what, input board_t exp,
			input board_t act);
		if (act !== exp)
			abortRun($sformatf("ERR %s %s expected %03h actual %03h", name, what, exp, act));
	endtask

	task automatic resultCheck(input string name, input result_t exp, input result_t act);
		if (act !== exp)
			abortRun($sformatf("ERR %s result expected %0d actual %0d", name, exp, act));
	endtask

	task automatic invalidCheck(input string name, input logic exp, input logic act);
		if (act !== exp)
			abortRun($sformatf("ERR %s invalidMove expected %b actual %b", name, exp, act));
	endtask

	task automatic digitCheck(input string name, input string what, input bcdDigit_t exp,
			input bcdDigit_t act);
		if (act !== exp)
			abortRun($sformatf("ERR %s %s expected %0d actual %0d", name, what, exp, act));
	endtask

	function automatic bcdDigit_t segToDigit(input segCode_t code);
		bcdDigit_t d;
		d = 4'hf;   // no code matched
		for (int i = 0; i < 10; i++) begin
			if (segCodes[i] == code)
				d = bcdDigit_t'(i);
		end
		return d;
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic loadCases();
		int fd;
		int n;
		int arg;
		int res;
		int inv;
		int xt;
		int xo;
		int ot;
		int oo;
		string line;
		string name;
		string op;
		board_t xb;
		board_t ob;
		fd = $fopen("tests/tttCases.txt", "r");
		if (fd == 0)
			abortRun("could not open tests/tttCases.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %h %d %d %d %d %d %d",
				name, op, arg, xb, ob, res, inv, xt, xo, ot, oo);
			if (n <= 0)
				continue;   // blank line
			if (n != 11)
				abortRun($sformatf("malformed line in cases file: %s", line));
			nameQ.push_back(name);
			opQ.push_back(op);
			argQ.push_back(arg);
			xQ.push_back(xb);
			oQ.push_back(ob);
			resQ.push_back(result_t'(res));
			invQ.push_back(inv[0]);
			digQ.push_back(bcdDigit_t'(xt));
			digQ.push_back(bcdDigit_t'(xo));
			digQ.push_back(bcdDigit_t'(ot));
			digQ.push_back(bcdDigit_t'(oo));
		end
		$fclose(fd);
	endtask

	// hold then release, entering and leaving 1 ns after an edge
	task automatic pulseInputs(input logic [2:0] rows, input logic [2:0] cols,
			input logic ng, input logic cs);
		keyRows = rows;
		keyCols = cols;
		newGameBtn = ng;
		clearScoreBtn = cs;
		repeat (holdCycles) @(posedge clk);
		#1;
		keyRows = 3'b000;
		keyCols = 3'b000;
		newGameBtn = 1'b0;
		clearScoreBtn = 1'b0;
		repeat (holdCycles) @(posedge clk);
		#1;
	endtask

	// one full rotation of the multiplexer
	task automatic scanDisplay();
		logic [3:0] seen;
		int pos;
		seen = 4'b0000;
		repeat (4 * refreshDiv) begin
			case (an)
				4'b1110: pos = 0;
				4'b1101: pos = 1;
				4'b1011: pos = 2;
				4'b0111: pos = 3;
				default: pos = -1;   // blank or not one-cold
			endcase
			if (pos >= 0) begin
				shownDigit[pos] = segToDigit(seg);
				seen[pos] = 1'b1;
			end
			@(posedge clk);
			#1;
		end
		if (seen != 4'b1111)
			abortRun($sformatf("display scan never selected some digits, seen mask %b", seen));
	endtask

	task automatic runCase(input int idx);
		string name;
		int arg;
		name = nameQ[idx];
		arg = argQ[idx];
		if (opQ[idx] == "P")
			pulseInputs(3'b001 << (arg / 3), 3'b001 << (arg % 3), 1'b0, 1'b0);
		else if (opQ[idx] == "K")
			pulseInputs(arg[5:3], arg[2:0], 1'b0, 1'b0);   // raw rows and columns
		else if (opQ[idx] == "N")
			pulseInputs(3'b000, 3'b000, 1'b1, 1'b0);
		else if (opQ[idx] == "C")
			pulseInputs(3'b000, 3'b000, 1'b0, 1'b1);
		else
			abortRun($sformatf("unknown operation %s in case %s", opQ[idx], name));
		boardCheck(name, "xBoard", xQ[idx], xBoard);
		boardCheck(name, "oBoard", oQ[idx], oBoard);
		resultCheck(name, resQ[idx], result);
		invalidCheck(name, invQ[idx], invalidMove);
		scanDisplay();
		// X score on the two left digits
		digitCheck(name, "xTens", digQ[4 * idx], shownDigit[3]);
		digitCheck(name, "xOnes", digQ[4 * idx + 1], shownDigit[2]);
		digitCheck(name, "oTens", digQ[4 * idx + 2], shownDigit[1]);
		digitCheck(name, "oOnes", digQ[4 * idx + 3], shownDigit[0]);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		keyRows = 3'b000;
		keyCols = 3'b000;
		newGameBtn = 1'b0;
		clearScoreBtn = 1'b0;
		cycleCount = 0;
		cycleLimit = 0;
		loadCases();
		if (nameQ.size() == 0)
			abortRun("cases file holds no cases");
		cycleLimit = nameQ.size() * cyclesPerCase;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < nameQ.size(); i++)
			runCase(i);
		$display("%0d cases matched", nameQ.size());
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- tests/tttCases.txt
# name op arg xBoard oBoard result invalid xTens xOnes oTens oOnes (arg, boards in hex)
# op P arg=cell, K arg=rows*8+cols raw keys, N new game, C clear; result 0 play 1 X 2 O 3 draw
g1_x4      P 4  010 000 0 0 0 0 0 0
g1_o0      P 0  010 001 0 0 0 0 0 0
g1_taken   P 4  010 001 0 1 0 0 0 0
g1_x3      P 3  018 001 0 0 0 0 0 0
g1_o8      P 8  018 101 0 0 0 0 0 0
g1_rowWin  P 5  038 101 1 0 0 1 0 0
g1_late    P 2  038 101 1 1 0 1 0 0
g1_new     N 0  000 000 0 0 0 1 0 0
g2_x0      P 0  001 000 0 0 0 1 0 0
g2_o1      P 1  001 002 0 0 0 1 0 0
g2_x2      P 2  005 002 0 0 0 1 0 0
g2_o4      P 4  005 012 0 0 0 1 0 0
g2_x6      P 6  045 012 0 0 0 1 0 0
g2_colWin  P 7  045 092 2 0 0 1 0 1
g2_new     N 0  000 000 0 0 0 1 0 1
g3_x0      P 0  001 000 0 0 0 1 0 1
g3_o1      P 1  001 002 0 0 0 1 0 1
g3_x4      P 4  011 002 0 0 0 1 0 1
g3_o2      P 2  011 006 0 0 0 1 0 1
g3_diagWin P 8  111 006 1 0 0 2 0 1
g3_new     N 0  000 000 0 0 0 2 0 1
d_x0       P 0  001 000 0 0 0 2 0 1
d_o4       P 4  001 010 0 0 0 2 0 1
d_x8       P 8  101 010 0 0 0 2 0 1
d_o1       P 1  101 012 0 0 0 2 0 1
d_x7       P 7  181 012 0 0 0 2 0 1
d_o6       P 6  181 052 0 0 0 2 0 1
d_x2       P 2  185 052 0 0 0 2 0 1
d_o5       P 5  185 072 0 0 0 2 0 1
d_x3       P 3  18d 072 3 0 0 2 0 1
d_new      N 0  000 000 0 0 0 2 0 1
clr        C 0  000 000 0 0 0 0 0 0
k_twoRows  K 19 000 000 0 0 0 0 0 0
k_twoCols  K 0e 000 000 0 0 0 0 0 0
k_single   P 4  010 000 0 0 0 0 0 0

//--- flist.f
common/tttPkg.sv
keypad/debouncer.sv
keypad/keypadDecoder.sv
game/gameBoard.sv
game/scoreKeeper.sv
display/segDisplay.sv
design/tttTop.sv
tests/tttTb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tttTb
FLIST      := flist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
